// File: compile.f
logic/pwm_pkg.sv
logic/axil_skid_buffer.sv
logic/axil_register_bridge.sv
logic/pwm_register_bank.sv
logic/pwm_carrier_generator.sv
logic/pwm_subsystem.sv
verif/tb_clock_gen.sv
verif/pwm_subsystem_sva.sv
verif/pwm_subsystem_tb.sv

// File: Bender.yml
package:
  name: pwm_subsystem

sources:
  - files:
      - logic/pwm_pkg.sv
      - logic/axil_skid_buffer.sv
      - logic/axil_register_bridge.sv
      - logic/pwm_register_bank.sv
      - logic/pwm_carrier_generator.sv
      - logic/pwm_subsystem.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/pwm_subsystem_sva.sv
      - verif/pwm_subsystem_tb.sv

// File: verif/pwm_subsystem_tb.sv
module pwm_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int kind_write = 0;
    localparam int kind_read = 1;
    localparam int kind_read_below = 2;
    localparam int cycles_per_entry = 40;
    localparam int pwm_window_cycles = 300;
    localparam int pwm_period = 8;
    localparam int pwm_duty = 3;

    typedef struct {
        int                             kind;
        logic [pwm_pkg::addr_width-1:0] addr;
        logic [pwm_pkg::data_width-1:0] data;
        logic [pwm_pkg::strb_width-1:0] strb;
        logic [pwm_pkg::data_width-1:0] expected;
    } entry_t;

    logic                           clock;
    logic                           reset;
    logic [pwm_pkg::addr_width-1:0] awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [pwm_pkg::data_width-1:0] wdata;
    logic [pwm_pkg::strb_width-1:0] wstrb;
    logic                           wvalid;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [pwm_pkg::addr_width-1:0] araddr;
    logic                           arvalid;
    logic                           arready;
    logic [pwm_pkg::data_width-1:0] rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;
    logic                           pwm_out;

    entry_t tests[$];
    integer seed = 32'hb8d6fd74;
    int pass_count = 0;
    int fail_count = 0;
    int writes_issued = 0;
    int reads_issued = 0;
    int b_count = 0;
    int r_count = 0;
    bit b_pending = 1'b0;
    bit r_pending = 1'b0;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    pwm_subsystem uut (.*);

    // Each response offered by the DUT counts once while its valid is held
    always @(posedge clock) begin
        if (reset && bvalid && !b_pending) b_count++;
        if (reset && rvalid && !r_pending) r_count++;
        b_pending = reset && bvalid && !bready;
        r_pending = reset && rvalid && !rready;
    end

    function automatic logic [31:0] reg_address(input pwm_pkg::reg_addr_e index);
        return pwm_pkg::base_address + {index, 2'b00};
    endfunction

    function automatic void add_entry(input int kind, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [3:0] strb,
                                      input logic [31:0] expected);
        tests.push_back('{kind, addr, data, strb, expected});
    endfunction

    // Ready is given in about three cycles out of four
    function automatic bit random_ready();
        logic [31:0] value;
        value = $random(seed);
        return value[1:0] != 2'b00;
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        bit aw_fire;
        bit w_fire;
        bit b_fire;
        @(negedge clock);
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = strb;
        wvalid = 1'b1;
        while (awvalid || wvalid) begin
            aw_fire = awvalid && awready;
            w_fire = wvalid && wready;
            @(negedge clock);
            if (aw_fire) awvalid = 1'b0;
            if (w_fire) wvalid = 1'b0;
        end
        b_fire = 1'b0;
        while (!b_fire) begin
            bready = random_ready();
            b_fire = bvalid && bready;
            resp = bresp;
            @(negedge clock);
        end
        bready = 1'b0;
        writes_issued++;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        bit ar_fire;
        bit r_fire;
        @(negedge clock);
        araddr = addr;
        arvalid = 1'b1;
        while (arvalid) begin
            ar_fire = arready;
            @(negedge clock);
            if (ar_fire) arvalid = 1'b0;
        end
        r_fire = 1'b0;
        while (!r_fire) begin
            rready = random_ready();
            r_fire = rvalid && rready;
            data = rdata;
            resp = rresp;
            @(negedge clock);
        end
        rready = 1'b0;
        reads_issued++;
    endtask

    task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] strb, inout bit ok);
        logic [1:0] resp;
        axi_write(addr, data, strb, resp);
        if (resp !== pwm_pkg::resp_okay) begin
            $display("** Error at %0t: bresp = %b, expected %b", $time, resp,
                     pwm_pkg::resp_okay);
            ok = 1'b0;
        end
    endtask

    task automatic record_result(input string name, input bit ok);
        $display("%s: %s", name, ok ? "ok" : "FAIL");
        if (ok) pass_count++;
        else fail_count++;
    endtask

    // Aligns to a rising edge of the output, which starts a carrier period
    task automatic check_pwm_waveform(output bit ok);
        bit expected;
        ok = 1'b1;
        while (pwm_out !== 1'b0) @(negedge clock);
        while (pwm_out !== 1'b1) @(negedge clock);
        for (int cycle = 0; cycle < 4 * pwm_period; cycle++) begin
            expected = (cycle % pwm_period) < pwm_duty;
            if (pwm_out !== expected) begin
                $display("** Error at %0t: pwm_out = %b, expected %b", $time, pwm_out,
                         expected);
                ok = 1'b0;
            end
            @(negedge clock);
        end
    endtask

    task automatic check_pwm_idle(output bit ok);
        ok = 1'b1;
        repeat (4 * pwm_period) begin
            if (pwm_out !== 1'b0) begin
                $display("** Error at %0t: pwm_out = %b, expected 0", $time, pwm_out);
                ok = 1'b0;
            end
            @(negedge clock);
        end
    endtask

    task automatic run_watchdog(input int limit_cycles);
        repeat (limit_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the sequence never completed",
                 limit_cycles);
        $display("test failed");
        $finish;
    endtask

    initial begin
        logic [31:0] read_data;
        logic [1:0]  resp;
        bit          test_ok;
        string       name;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;

        // Reset values
        add_entry(kind_read, reg_address(pwm_pkg::reg_control), '0, '0, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_period), '0, '0, pwm_pkg::period_reset);
        add_entry(kind_read, reg_address(pwm_pkg::reg_duty), '0, '0, pwm_pkg::duty_reset);
        // Full and partial strobes
        add_entry(kind_write, reg_address(pwm_pkg::reg_period), 32'h1234_5678, 4'hf, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_period), '0, '0, 32'h1234_5678);
        add_entry(kind_write, reg_address(pwm_pkg::reg_duty), 32'hdead_beef, 4'b0101, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_duty), '0, '0, 32'h00ad_00ef);
        add_entry(kind_write, reg_address(pwm_pkg::reg_period), 32'haabb_ccdd, 4'b1010, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_period), '0, '0, 32'haa34_cc78);
        // Read-only and unmapped targets
        add_entry(kind_write, reg_address(pwm_pkg::reg_status), 32'hffff_ffff, 4'hf, '0);
        add_entry(kind_write, pwm_pkg::base_address + 32'h10, 32'hffff_ffff, 4'hf, '0);
        add_entry(kind_write, pwm_pkg::base_address + 32'h100, 32'hffff_ffff, 4'hf, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_control), '0, '0, '0);
        add_entry(kind_read, reg_address(pwm_pkg::reg_period), '0, '0, 32'haa34_cc78);
        add_entry(kind_read, reg_address(pwm_pkg::reg_duty), '0, '0, 32'h00ad_00ef);
        // These alias onto period and duty if the upper address bits are ignored
        add_entry(kind_read, pwm_pkg::base_address + 32'h14, '0, '0, '0);
        add_entry(kind_read, pwm_pkg::base_address - 32'h8, '0, '0, '0);
        // Short period so the live counter has to wrap before the read
        add_entry(kind_write, reg_address(pwm_pkg::reg_period), 32'd3, 4'hf, '0);
        add_entry(kind_write, reg_address(pwm_pkg::reg_control), 32'h1, 4'b0001, '0);
        add_entry(kind_read_below, reg_address(pwm_pkg::reg_status), '0, '0, 32'd3);
        add_entry(kind_read, reg_address(pwm_pkg::reg_control), '0, '0, 32'h1);
        add_entry(kind_write, reg_address(pwm_pkg::reg_control), 32'h0, 4'hf, '0);

        fork
            run_watchdog(tests.size() * cycles_per_entry + pwm_window_cycles);
        join_none

        wait (reset === 1'b1);

        foreach (tests[i]) begin
            test_ok = 1'b1;
            if (tests[i].kind == kind_write) begin
                write_and_check(tests[i].addr, tests[i].data, tests[i].strb, test_ok);
            end else begin
                axi_read(tests[i].addr, read_data, resp);
                if (resp !== pwm_pkg::resp_okay) begin
                    $display("** Error at %0t: rresp = %b, expected %b", $time, resp,
                             pwm_pkg::resp_okay);
                    test_ok = 1'b0;
                end
                if (tests[i].kind == kind_read && read_data !== tests[i].expected) begin
                    $display("** Error at %0t: rdata = %h, expected %h", $time, read_data,
                             tests[i].expected);
                    test_ok = 1'b0;
                end
                if (tests[i].kind == kind_read_below && !(read_data < tests[i].expected)) begin
                    $display("** Error at %0t: rdata = %h, expected below %h", $time,
                             read_data, tests[i].expected);
                    test_ok = 1'b0;
                end
            end
            name = $sformatf("Entry %0d %s 0x%h", i,
                             tests[i].kind == kind_write ? "write" : "read", tests[i].addr);
            record_result(name, test_ok);
        end

        // Carrier with period 8 and duty 3
        test_ok = 1'b1;
        write_and_check(reg_address(pwm_pkg::reg_period), pwm_period, 4'hf, test_ok);
        write_and_check(reg_address(pwm_pkg::reg_duty), pwm_duty, 4'hf, test_ok);
        write_and_check(reg_address(pwm_pkg::reg_control), 32'h1, 4'hf, test_ok);
        record_result("PWM setup", test_ok);
        check_pwm_waveform(test_ok);
        record_result("PWM 3 of 8 over 4 periods", test_ok);
        test_ok = 1'b1;
        write_and_check(reg_address(pwm_pkg::reg_control), 32'h0, 4'hf, test_ok);
        if (test_ok) check_pwm_idle(test_ok);
        record_result("PWM idle after disable", test_ok);

        test_ok = 1'b1;
        if (b_count != writes_issued) begin
            $display("** Error at %0t: B responses = %0d, expected %0d", $time, b_count,
                     writes_issued);
            test_ok = 1'b0;
        end
        if (r_count != reads_issued) begin
            $display("** Error at %0t: R responses = %0d, expected %0d", $time, r_count,
                     reads_issued);
            test_ok = 1'b0;
        end
        record_result("Response counts", test_ok);

        $display("Summary: %0d ok, %0d with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verif/pwm_subsystem_sva.sv
module pwm_subsystem_sva (
    input logic                           clock,
    input logic                           reset,
    input logic [pwm_pkg::addr_width-1:0] awaddr,
    input logic                           awvalid,
    input logic                           awready,
    input logic [pwm_pkg::data_width-1:0] wdata,
    input logic [pwm_pkg::strb_width-1:0] wstrb,
    input logic                           wvalid,
    input logic                           wready,
    input logic                           bvalid,
    input logic                           bready,
    input logic [pwm_pkg::addr_width-1:0] araddr,
    input logic                           arvalid,
    input logic                           arready,
    input logic [pwm_pkg::data_width-1:0] rdata,
    input logic                           rvalid,
    input logic                           rready
);
    timeunit 1ns;
    timeprecision 100ps;

    // A raised valid holds with stable payload until its handshake
    aw_stable: assert property (@(posedge clock) disable iff (!reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    w_stable: assert property (@(posedge clock) disable iff (!reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid dropped or write data changed before wready");

    ar_stable: assert property (@(posedge clock) disable iff (!reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    b_stable: assert property (@(posedge clock) disable iff (!reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_stable: assert property (@(posedge clock) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped or rdata changed before rready");

    b_idle_after_reset: assert property (@(posedge clock)
        !reset |=> !bvalid)
        else $error("bvalid high right after reset");

    // Handshake edge, then rd_en, rd_valid and rvalid register on the next edges
    r_latency: assert property (@(posedge clock) disable iff (!reset)
        arvalid && arready |-> ##3 $rose(rvalid))
        else $error("rvalid did not rise two edges after the AR handshake edge");

endmodule

bind pwm_subsystem pwm_subsystem_sva handshake_checks (.*);

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Active-low reset held over the first three rising edges
    initial begin
        reset = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

// File: logic/pwm_subsystem.sv
module pwm_subsystem (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [pwm_pkg::addr_width-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [pwm_pkg::data_width-1:0] wdata,
    input  logic [pwm_pkg::strb_width-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [pwm_pkg::addr_width-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [pwm_pkg::data_width-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           pwm_out
);

    logic                                wr_en;
    logic [pwm_pkg::reg_index_width-1:0] wr_index;
    logic [pwm_pkg::data_width-1:0]      wr_data;
    logic [pwm_pkg::strb_width-1:0]      wr_strb;
    logic                                rd_en;
    logic [pwm_pkg::reg_index_width-1:0] rd_index;
    logic                                rd_valid;
    logic [pwm_pkg::data_width-1:0]      rd_data;
    logic                                enable;
    logic [pwm_pkg::data_width-1:0]      period;
    logic [pwm_pkg::data_width-1:0]      duty;
    logic [pwm_pkg::data_width-1:0]      counter;

    axil_register_bridge bridge (
        .clock(clock),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_index(rd_index),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

    pwm_register_bank bank (
        .clock(clock),
        .reset(reset),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_index(rd_index),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .counter(counter),
        .enable(enable),
        .period(period),
        .duty(duty)
    );

    pwm_carrier_generator generator (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .period(period),
        .duty(duty),
        .counter(counter),
        .pwm_out(pwm_out)
    );

endmodule

// File: logic/pwm_carrier_generator.sv
module pwm_carrier_generator (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [pwm_pkg::data_width-1:0] period,
    input  logic [pwm_pkg::data_width-1:0] duty,
    output logic [pwm_pkg::data_width-1:0] counter,
    output logic                           pwm_out
);

    logic period_short;
    logic at_wrap;

    // Periods of zero or one leave nothing to count
    assign period_short = period <= 1;
    assign at_wrap = counter >= period - 1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
        end else if (!enable) begin
            counter <= '0;
        end else if (period_short || at_wrap) begin
            // Also catches a period lowered below the running count
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // Compare stage, one cycle behind the counter
    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= enable && (counter < duty);
        end
    end

endmodule

// File: logic/pwm_register_bank.sv
module pwm_register_bank (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [pwm_pkg::reg_index_width-1:0] wr_index,
    input  logic [pwm_pkg::data_width-1:0]      wr_data,
    input  logic [pwm_pkg::strb_width-1:0]      wr_strb,
    input  logic                                rd_en,
    input  logic [pwm_pkg::reg_index_width-1:0] rd_index,
    output logic                                rd_valid,
    output logic [pwm_pkg::data_width-1:0]      rd_data,
    input  logic [pwm_pkg::data_width-1:0]      counter,
    output logic                                enable,
    output logic [pwm_pkg::data_width-1:0]      period,
    output logic [pwm_pkg::data_width-1:0]      duty
);

    logic [pwm_pkg::data_width-1:0] control_q;
    logic [pwm_pkg::data_width-1:0] write_current;
    logic [pwm_pkg::data_width-1:0] write_merged;
    logic [pwm_pkg::data_width-1:0] read_value;

    // Present value of the addressed register, for strobe merging
    always_comb begin
        case (pwm_pkg::reg_addr_e'(wr_index))
            pwm_pkg::reg_control: write_current = control_q;
            pwm_pkg::reg_period:  write_current = period;
            pwm_pkg::reg_duty:    write_current = duty;
            default:              write_current = '0;
        endcase
        for (int lane = 0; lane < pwm_pkg::strb_width; lane++) begin
            write_merged[lane*8 +: 8] = wr_strb[lane] ? wr_data[lane*8 +: 8]
                                                      : write_current[lane*8 +: 8];
        end
    end

    // Status index is read-only, so it has no case here
    always_ff @(posedge clock) begin
        if (!reset) begin
            control_q <= '0;
            period <= pwm_pkg::period_reset;
            duty <= pwm_pkg::duty_reset;
        end else if (wr_en) begin
            case (pwm_pkg::reg_addr_e'(wr_index))
                pwm_pkg::reg_control: control_q <= write_merged;
                pwm_pkg::reg_period:  period <= write_merged;
                pwm_pkg::reg_duty:    duty <= write_merged;
                default: ;
            endcase
        end
    end

    assign enable = control_q[0];

    always_comb begin
        case (pwm_pkg::reg_addr_e'(rd_index))
            pwm_pkg::reg_control: read_value = control_q;
            pwm_pkg::reg_period:  read_value = period;
            pwm_pkg::reg_duty:    read_value = duty;
            pwm_pkg::reg_status:  read_value = counter;
            default:              read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= read_value;
        end
    end

endmodule

// File: logic/axil_register_bridge.sv
module axil_register_bridge (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [pwm_pkg::addr_width-1:0]      awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [pwm_pkg::data_width-1:0]      wdata,
    input  logic [pwm_pkg::strb_width-1:0]      wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [pwm_pkg::addr_width-1:0]      araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [pwm_pkg::data_width-1:0]      rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    output logic                                wr_en,
    output logic [pwm_pkg::reg_index_width-1:0] wr_index,
    output logic [pwm_pkg::data_width-1:0]      wr_data,
    output logic [pwm_pkg::strb_width-1:0]      wr_strb,
    output logic                                rd_en,
    output logic [pwm_pkg::reg_index_width-1:0] rd_index,
    input  logic                                rd_valid,
    input  logic [pwm_pkg::data_width-1:0]      rd_data
);

    logic                              aw_valid;
    logic [pwm_pkg::addr_width-1:0]    aw_addr;
    logic                              w_valid;
    logic [pwm_pkg::data_width-1:0]    w_data;
    logic [pwm_pkg::strb_width-1:0]    w_strb;
    logic                              write_fire;
    logic [pwm_pkg::addr_width-1:0]    wr_offset;

    logic                              ar_in_valid;
    logic                              ar_in_ready;
    logic                              ar_valid;
    logic [pwm_pkg::addr_width-1:0]    ar_addr;
    logic                              ar_fire;
    logic [pwm_pkg::addr_width-1:0]    rd_offset;
    logic                              read_busy;
    logic                              rd_mapped;

    axil_skid_buffer #(
        .data_width(pwm_pkg::addr_width),
        .register_output(1'b0)
    ) aw_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(awvalid),
        .in_ready(awready),
        .in_data(awaddr),
        .out_valid(aw_valid),
        .out_ready(write_fire),
        .out_data(aw_addr)
    );

    axil_skid_buffer #(
        .data_width(pwm_pkg::data_width + pwm_pkg::strb_width),
        .register_output(1'b0)
    ) w_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(wvalid),
        .in_ready(wready),
        .in_data({wdata, wstrb}),
        .out_valid(w_valid),
        .out_ready(write_fire),
        .out_data({w_data, w_strb})
    );

    // A write needs both halves and a free B slot
    assign write_fire = aw_valid && w_valid && (!bvalid || bready);
    assign wr_offset = aw_addr - pwm_pkg::base_address;

    // Unmapped writes still get a response but never reach the bank
    assign wr_en = write_fire && (wr_offset[pwm_pkg::addr_width-1:pwm_pkg::reg_index_width+2] == '0);
    assign wr_index = wr_offset[pwm_pkg::reg_index_width+1:2];
    assign wr_data = w_data;
    assign wr_strb = w_strb;

    always_ff @(posedge clock) begin
        if (!reset) begin
            bvalid <= 1'b0;
        end else if (write_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign bresp = pwm_pkg::resp_okay;

    // Only one read in flight, AR is closed until R is accepted
    assign ar_in_valid = arvalid && !read_busy;
    assign arready = ar_in_ready && !read_busy;
    assign ar_fire = ar_valid && !read_busy;
    assign rd_offset = ar_addr - pwm_pkg::base_address;

    axil_skid_buffer #(
        .data_width(pwm_pkg::addr_width),
        .register_output(1'b0)
    ) ar_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(ar_in_valid),
        .in_ready(ar_in_ready),
        .in_data(araddr),
        .out_valid(ar_valid),
        .out_ready(!read_busy),
        .out_data(ar_addr)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_busy <= 1'b0;
            rd_en <= 1'b0;
        end else begin
            rd_en <= ar_fire;
            if (ar_fire) begin
                read_busy <= 1'b1;
            end else if (rvalid && rready) begin
                read_busy <= 1'b0;
            end
        end
    end

    // Index and range flag stay put for the whole read
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rd_index <= rd_offset[pwm_pkg::reg_index_width+1:2];
            rd_mapped <= rd_offset[pwm_pkg::addr_width-1:pwm_pkg::reg_index_width+2] == '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (rd_valid) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_valid) begin
            rdata <= rd_mapped ? rd_data : '0;
        end
    end

    assign rresp = pwm_pkg::resp_okay;

endmodule

// File: logic/axil_skid_buffer.sv
module axil_skid_buffer #(
    parameter int data_width = 32,
    parameter bit register_output = 1'b0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [data_width-1:0] in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [data_width-1:0] out_data
);

    logic                  spare_valid;
    logic [data_width-1:0] spare_data;

    // Ready only depends on the spare slot, so it comes straight from a flop
    assign in_ready = !spare_valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            spare_valid <= 1'b0;
        end else if (in_valid && in_ready && out_valid && !out_ready) begin
            spare_valid <= 1'b1;
        end else if (out_ready) begin
            spare_valid <= 1'b0;
        end
    end

    // Capture incoming data while the spare slot is empty
    always_ff @(posedge clock) begin
        if (!spare_valid) begin
            spare_data <= in_data;
        end
    end

    generate
        if (register_output) begin : gen_registered
            logic                  out_valid_q;
            logic [data_width-1:0] out_data_q;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid_q <= 1'b0;
                end else if (!out_valid_q || out_ready) begin
                    out_valid_q <= spare_valid || in_valid;
                end
            end

            // Spare entry drains first so ordering is kept
            always_ff @(posedge clock) begin
                if (!out_valid_q || out_ready) begin
                    out_data_q <= spare_valid ? spare_data : in_data;
                end
            end

            assign out_valid = out_valid_q;
            assign out_data = out_data_q;
        end else begin : gen_passthrough
            assign out_valid = in_valid || spare_valid;
            assign out_data = spare_valid ? spare_data : in_data;
        end
    endgenerate

endmodule

// File: logic/pwm_pkg.sv
package pwm_pkg;

    // Bus geometry
    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int strb_width = data_width / 8;

    // Byte address of register 0
    localparam logic [addr_width-1:0] base_address = 32'h4000_0000;

    localparam int reg_index_width = 2;

    // Word indices of the register map
    typedef enum logic [reg_index_width-1:0] {
        reg_control = 2'd0,
        reg_period  = 2'd1,
        reg_duty    = 2'd2,
        reg_status  = 2'd3
    } reg_addr_e;

    // Reset values of the carrier settings
    localparam logic [data_width-1:0] period_reset = 32'd100;
    localparam logic [data_width-1:0] duty_reset = 32'd0;

    // AXI response code, every transfer answers OKAY
    localparam logic [1:0] resp_okay = 2'b00;

endpackage
